/* src/usb_host_pkg.sv */
`default_nettype none

package usb_host_pkg;

  // 4-bit USB PIDs, standard codes
  typedef enum logic [3:0] {
    PID_OUT   = 4'b0001,
    PID_IN    = 4'b1001,
    PID_DATA0 = 4'b0011,
    PID_ACK   = 4'b0010,
    PID_NAK   = 4'b1010
  } pid_t;

  // Sync byte, bit 0 goes on the line first
  localparam logic [7:0] SYNC_PATTERN = 8'b0000_0001;

  // Address and data endpoints of the memory device
  localparam logic [3:0] ADDR_ENDP = 4'd4;
  localparam logic [3:0] DATA_ENDP = 4'd8;

  // NAKs tolerated before the transaction gives up
  localparam int MAX_RETRIES = 3;

  // Cycles from sent until a reply must have started
  localparam int RESPONSE_TIMEOUT = 64;

  // Counter widths for the transaction blocks
  localparam int RETRY_W = $clog2(MAX_RETRIES + 1);
  localparam int TIMER_W = $clog2(RESPONSE_TIMEOUT + 1);

  // One packet for the sender
  // endp used by tokens only, data by DATA0 only
  typedef struct packed {
    pid_t        kind;
    logic [3:0]  endp;
    logic [63:0] data;
  } tx_request_t;

  // One received packet
  // payload only meaningful after a DATA0
  typedef struct packed {
    logic        ack;
    logic        nak;
    logic        data0;
    logic [63:0] payload;
  } rx_event_t;

endpackage

`default_nettype wire

/* src/packet_sender.sv */
`timescale 1ns/1ps
`default_nettype none

module packet_sender import usb_host_pkg::*; (
  input  logic        clock,
  input  logic        reset_n,
  input  logic        send,
  input  tx_request_t request,
  output logic        DP_out,
  output logic        DM_out,
  output logic        sent,
  output logic        busy
);

  typedef enum logic [1:0] {S_IDLE, S_BITS, S_EOP} state_t;

  state_t      state;
  logic [79:0] frame;
  logic [6:0]  frame_len;
  logic [79:0] shift_q;
  logic [6:0]  bits_left;
  logic [1:0]  eop_cnt;
  logic        level;
  logic [3:0]  pid_bits;
  logic        tx_bit;
  logic        nrzi_level;

  assign pid_bits = request.kind;

  // Whole packet laid out LSB first
  // sync, PID with complement, then the field of this PID
  always_comb begin
    frame     = {64'd0, ~pid_bits, pid_bits, SYNC_PATTERN};
    frame_len = 7'd16;
    case (request.kind)
      PID_OUT, PID_IN: begin
        frame     = {60'd0, request.endp, ~pid_bits, pid_bits, SYNC_PATTERN};
        frame_len = 7'd20;
      end
      PID_DATA0: begin
        frame     = {request.data, ~pid_bits, pid_bits, SYNC_PATTERN};
        frame_len = 7'd80;
      end
      default: ;
    endcase
  end

  // First bit comes straight from the frame, the rest from the shifter
  assign tx_bit = (state == S_IDLE) ? frame[0] : shift_q[0];

  // NRZI: a zero flips the level, a one holds it
  assign nrzi_level = level ~^ tx_bit;

  // Packet bits, no control state here
  always_ff @(posedge clock) begin
    if (state == S_IDLE)
      shift_q <= frame >> 1;
    else if (state == S_BITS)
      shift_q <= shift_q >> 1;
  end

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      state     <= S_IDLE;
      bits_left <= '0;
      eop_cnt   <= '0;
      level     <= 1'b1;
      DP_out    <= 1'b1;
      DM_out    <= 1'b0;
      sent      <= 1'b0;
    end else begin
      sent <= 1'b0;
      case (state)
        S_IDLE: begin
          if (send) begin
            level     <= nrzi_level;
            DP_out    <= nrzi_level;
            DM_out    <= ~nrzi_level;
            bits_left <= frame_len - 7'd1;
            state     <= S_BITS;
          end
        end
        S_BITS: begin
          if (bits_left != '0) begin
            level     <= nrzi_level;
            DP_out    <= nrzi_level;
            DM_out    <= ~nrzi_level;
            bits_left <= bits_left - 7'd1;
          end else begin
            // First SE0 cycle
            DP_out  <= 1'b0;
            DM_out  <= 1'b0;
            eop_cnt <= '0;
            state   <= S_EOP;
          end
        end
        S_EOP: begin
          eop_cnt <= eop_cnt + 2'd1;
          if (eop_cnt == 2'd1) begin
            // Back to idle J, ready for next sync
            DP_out <= 1'b1;
            DM_out <= 1'b0;
            level  <= 1'b1;
          end else if (eop_cnt == 2'd2) begin
            sent  <= 1'b1;
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  assign busy = (state != S_IDLE);

  // Requests are only accepted between packets
  assert property (@(posedge clock) disable iff (!reset_n) send |-> !busy);

endmodule

`default_nettype wire

/* src/packet_receiver.sv */
`timescale 1ns/1ps
`default_nettype none

module packet_receiver import usb_host_pkg::*; (
  input  logic      clock,
  input  logic      reset_n,
  input  logic      host_sending,
  input  logic      DP_in,
  input  logic      DM_in,
  output logic      rx_start,
  output logic      rx_valid,
  output rx_event_t rx_event
);

  typedef enum logic [2:0] {R_HUNT, R_PID, R_DATA, R_END, R_EOP, R_DROP} state_t;

  state_t      state;
  logic        prev_dp;
  logic        rx_bit;
  logic        se0;
  logic [7:0]  byte_q;
  logic [7:0]  byte_next;
  logic        pid_ok;
  logic [5:0]  bit_cnt;
  logic [3:0]  pid_q;
  logic        ack_q;
  logic        nak_q;
  logic        data0_q;
  logic [63:0] data_sr;
  logic [63:0] payload_q;

  assign se0 = !DP_in && !DM_in;

  // NRZI decode, unchanged level means a one
  assign rx_bit = (DP_in == prev_dp);

  // Bits enter at the top so the oldest ends up in bit 0
  assign byte_next = {rx_bit, byte_q[7:1]};

  // Upper nibble must be the complement of the PID
  assign pid_ok = (byte_next[7:4] == ~byte_next[3:0]);

  // Payload collection and holding
  always_ff @(posedge clock) begin
    if (state == R_DATA)
      data_sr <= {rx_bit, data_sr[63:1]};
    if (state == R_EOP && !se0 && pid_q == PID_DATA0)
      payload_q <= data_sr;
  end

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      state    <= R_HUNT;
      prev_dp  <= 1'b1;
      byte_q   <= '0;
      bit_cnt  <= '0;
      pid_q    <= '0;
      ack_q    <= 1'b0;
      nak_q    <= 1'b0;
      data0_q  <= 1'b0;
      rx_start <= 1'b0;
      rx_valid <= 1'b0;
    end else begin
      rx_start <= 1'b0;
      rx_valid <= 1'b0;
      prev_dp  <= DP_in;
      // SE0 marks a packet boundary, history starts over
      byte_q   <= se0 ? '0 : byte_next;
      if (host_sending) begin
        // Own traffic, line treated as idle J
        state   <= R_HUNT;
        prev_dp <= 1'b1;
        byte_q  <= '0;
      end else begin
        case (state)
          R_HUNT: begin
            if (!se0 && byte_next == SYNC_PATTERN) begin
              bit_cnt  <= '0;
              rx_start <= 1'b1;
              state    <= R_PID;
            end
          end
          R_PID: begin
            bit_cnt <= bit_cnt + 6'd1;
            if (se0) begin
              state <= R_HUNT;
            end else if (bit_cnt == 6'd7) begin
              bit_cnt <= '0;
              pid_q   <= byte_next[3:0];
              if (!pid_ok)
                state <= R_DROP;
              else if (byte_next[3:0] == PID_DATA0)
                state <= R_DATA;
              else
                state <= R_END;
            end
          end
          R_DATA: begin
            bit_cnt <= bit_cnt + 6'd1;
            if (se0)
              state <= R_HUNT;
            else if (bit_cnt == 6'd63)
              state <= R_END;
          end
          // Waiting out SE0 then the closing J
          R_END: if (se0) state <= R_EOP;
          R_EOP: begin
            if (!se0) begin
              ack_q    <= (pid_q == PID_ACK);
              nak_q    <= (pid_q == PID_NAK);
              data0_q  <= (pid_q == PID_DATA0);
              rx_valid <= 1'b1;
              state    <= R_HUNT;
            end
          end
          // Corrupt PID, skip to the end of the packet silently
          R_DROP: if (se0) state <= R_HUNT;
          default: state <= R_HUNT;
        endcase
      end
    end
  end

  assign rx_event = '{ack: ack_q, nak: nak_q, data0: data0_q, payload: payload_q};

endmodule

`default_nettype wire

/* src/out_transaction.sv */
`timescale 1ns/1ps
`default_nettype none

module out_transaction import usb_host_pkg::*; (
  input  logic        clock,
  input  logic        reset_n,
  input  logic        start,
  input  logic [3:0]  endp,
  input  logic [63:0] data,
  input  logic        sent,
  input  logic        rx_start,
  input  logic        rx_valid,
  input  rx_event_t   rx_event,
  output logic        send,
  output tx_request_t request,
  output logic        sending,
  output logic        done,
  output logic        success,
  output logic        failure
);

  typedef enum logic [1:0] {T_IDLE, T_TOKEN, T_DATA, T_WAIT} state_t;

  state_t             state;
  state_t             state_next;
  logic [3:0]         endp_q;
  logic [63:0]        data_q;
  logic [RETRY_W-1:0] retries;
  logic [TIMER_W-1:0] timer;
  logic               heard;
  logic               timed_out;
  logic               retry_ok;

  // No reply started within the window
  assign timed_out = !heard && (timer == TIMER_W'(RESPONSE_TIMEOUT));
  assign retry_ok  = (retries < RETRY_W'(MAX_RETRIES));
  assign sending   = (state == T_TOKEN) || (state == T_DATA);

  always_comb begin
    state_next = state;
    send       = 1'b0;
    done       = 1'b0;
    success    = 1'b0;
    failure    = 1'b0;
    request    = '{kind: PID_OUT, endp: endp_q, data: data_q};
    case (state)
      T_IDLE: begin
        if (start) begin
          // Endpoint not latched yet
          send         = 1'b1;
          request.endp = endp;
          state_next   = T_TOKEN;
        end
      end
      T_TOKEN: begin
        if (sent) begin
          send         = 1'b1;
          request.kind = PID_DATA0;
          state_next   = T_DATA;
        end
      end
      T_DATA: if (sent) state_next = T_WAIT;
      T_WAIT: begin
        if (rx_valid && rx_event.nak && retry_ok) begin
          // Start over from the token
          send       = 1'b1;
          state_next = T_TOKEN;
        end else if (rx_valid) begin
          done       = 1'b1;
          success    = rx_event.ack;
          failure    = !rx_event.ack;
          state_next = T_IDLE;
        end else if (timed_out) begin
          done       = 1'b1;
          failure    = 1'b1;
          state_next = T_IDLE;
        end
      end
      default: state_next = T_IDLE;
    endcase
  end

  // Token fields kept for the DATA0 and for retries
  always_ff @(posedge clock) begin
    if (state == T_IDLE && start) begin
      endp_q <= endp;
      data_q <= data;
    end
  end

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      state   <= T_IDLE;
      retries <= '0;
      timer   <= '0;
      heard   <= 1'b0;
    end else begin
      state <= state_next;
      if (state == T_IDLE)
        retries <= '0;
      else if (state == T_WAIT && state_next == T_TOKEN)
        retries <= retries + 1'b1;
      // Timer runs from sent until the sync of the reply
      if (sent) begin
        timer <= '0;
        heard <= 1'b0;
      end else if (state == T_WAIT) begin
        if (rx_start)
          heard <= 1'b1;
        else if (!heard)
          timer <= timer + 1'b1;
      end
    end
  end

  // A start outside idle would be lost
  assert property (@(posedge clock) disable iff (!reset_n) start |-> (state == T_IDLE));

endmodule

`default_nettype wire

/* src/in_transaction.sv */
`timescale 1ns/1ps
`default_nettype none

module in_transaction import usb_host_pkg::*; (
  input  logic        clock,
  input  logic        reset_n,
  input  logic        start,
  input  logic [3:0]  endp,
  input  logic        sent,
  input  logic        rx_start,
  input  logic        rx_valid,
  input  rx_event_t   rx_event,
  output logic        send,
  output tx_request_t request,
  output logic        sending,
  output logic        done,
  output logic        success,
  output logic        failure
);

  typedef enum logic [1:0] {T_IDLE, T_TOKEN, T_WAIT, T_ACK} state_t;

  state_t             state;
  state_t             state_next;
  logic [3:0]         endp_q;
  logic [RETRY_W-1:0] retries;
  logic [TIMER_W-1:0] timer;
  logic               heard;
  logic               timed_out;
  logic               retry_ok;

  assign timed_out = !heard && (timer == TIMER_W'(RESPONSE_TIMEOUT));
  assign retry_ok  = (retries < RETRY_W'(MAX_RETRIES));
  // Host owns the line for the token and for the closing ACK
  assign sending   = (state == T_TOKEN) || (state == T_ACK);

  always_comb begin
    state_next = state;
    send       = 1'b0;
    done       = 1'b0;
    success    = 1'b0;
    failure    = 1'b0;
    request    = '{kind: PID_IN, endp: endp_q, data: 64'd0};
    case (state)
      T_IDLE: begin
        if (start) begin
          send         = 1'b1;
          request.endp = endp;
          state_next   = T_TOKEN;
        end
      end
      T_TOKEN: if (sent) state_next = T_WAIT;
      T_WAIT: begin
        if (rx_valid && rx_event.data0) begin
          // Data in hand so acknowledge it
          send         = 1'b1;
          request.kind = PID_ACK;
          state_next   = T_ACK;
        end else if (rx_valid && rx_event.nak && retry_ok) begin
          send       = 1'b1;
          state_next = T_TOKEN;
        end else if (rx_valid || timed_out) begin
          // Out of retries, unexpected packet or silence
          done       = 1'b1;
          failure    = 1'b1;
          state_next = T_IDLE;
        end
      end
      T_ACK: begin
        // Success only once the ACK is out
        if (sent) begin
          done       = 1'b1;
          success    = 1'b1;
          state_next = T_IDLE;
        end
      end
      default: state_next = T_IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (state == T_IDLE && start)
      endp_q <= endp;
  end

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      state   <= T_IDLE;
      retries <= '0;
      timer   <= '0;
      heard   <= 1'b0;
    end else begin
      state <= state_next;
      if (state == T_IDLE)
        retries <= '0;
      else if (state == T_WAIT && state_next == T_TOKEN)
        retries <= retries + 1'b1;
      if (sent) begin
        timer <= '0;
        heard <= 1'b0;
      end else if (state == T_WAIT) begin
        if (rx_start)
          heard <= 1'b1;
        else if (!heard)
          timer <= timer + 1'b1;
      end
    end
  end

  // A start outside idle would be lost
  assert property (@(posedge clock) disable iff (!reset_n) start |-> (state == T_IDLE));

endmodule

`default_nettype wire

/* src/usb_rw_host.sv */
`timescale 1ns/1ps
`default_nettype none

module usb_rw_host import usb_host_pkg::*; (
  input  logic        clock,
  input  logic        reset_n,
  input  logic        DP_in,
  input  logic        DM_in,
  input  logic        read_start,
  input  logic        write_start,
  input  logic [15:0] read_mempage,
  input  logic [15:0] write_mempage,
  input  logic [63:0] write_data,
  output logic        DP_out,
  output logic        DM_out,
  output logic        sending,
  output logic        finished,
  output logic        read_success,
  output logic        write_success,
  output logic [63:0] read_data
);

  typedef enum logic [2:0] {IDLE, RD_ADDR, RD_DATA, WR_ADDR, WR_DATA} seq_t;

  seq_t        state;
  seq_t        state_next;
  logic        endp_sel;
  logic [1:0]  data_sel;
  logic [3:0]  txn_endp;
  logic [63:0] txn_data;
  logic        data_start;

  logic        out_start;
  logic        out_send;
  logic        out_sending;
  logic        out_done;
  logic        out_success;
  logic        out_failure;
  logic        in_start;
  logic        in_send;
  logic        in_sending;
  logic        in_done;
  logic        in_success;
  logic        in_failure;
  tx_request_t out_request;
  tx_request_t in_request;

  logic        tx_send;
  logic        tx_sent;
  logic        tx_busy;
  tx_request_t tx_request;
  logic        rx_start;
  logic        rx_valid;
  rx_event_t   rx_event;

  // Endpoint for the next transaction
  assign txn_endp = endp_sel ? DATA_ENDP : ADDR_ENDP;

  // Payload for the next OUT with pages in the top 16 bits
  always_comb begin
    case (data_sel)
      2'd0:    txn_data = {read_mempage, 48'd0};
      2'd1:    txn_data = {write_mempage, 48'd0};
      default: txn_data = write_data;
    endcase
  end

  // Sequencer where read wins over write when both arrive
  always_comb begin
    state_next    = state;
    out_start     = 1'b0;
    in_start      = 1'b0;
    endp_sel      = 1'b0;
    data_sel      = 2'd0;
    finished      = 1'b0;
    read_success  = 1'b0;
    write_success = 1'b0;
    case (state)
      IDLE: begin
        if (read_start) begin
          out_start  = 1'b1;
          state_next = RD_ADDR;
        end else if (write_start) begin
          out_start  = 1'b1;
          data_sel   = 2'd1;
          state_next = WR_ADDR;
        end
      end
      RD_ADDR: begin
        if (out_done && out_success) begin
          in_start   = 1'b1;
          endp_sel   = 1'b1;
          state_next = RD_DATA;
        end else if (out_done && out_failure) begin
          finished   = 1'b1;
          state_next = IDLE;
        end
      end
      RD_DATA: begin
        if (in_done && in_success) begin
          finished     = 1'b1;
          read_success = 1'b1;
          state_next   = IDLE;
        end else if (in_done && in_failure) begin
          finished   = 1'b1;
          state_next = IDLE;
        end
      end
      WR_ADDR: begin
        if (out_done && out_success) begin
          // Address accepted and data goes next
          state_next = WR_DATA;
        end else if (out_done && out_failure) begin
          finished   = 1'b1;
          state_next = IDLE;
        end
      end
      WR_DATA: begin
        endp_sel  = 1'b1;
        data_sel  = 2'd2;
        out_start = data_start;
        if (out_done && out_success) begin
          finished      = 1'b1;
          write_success = 1'b1;
          state_next    = IDLE;
        end else if (out_done && out_failure) begin
          finished   = 1'b1;
          state_next = IDLE;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      state      <= IDLE;
      data_start <= 1'b0;
    end else begin
      state      <= state_next;
      // Data OUT starts once the address OUT is back in idle
      data_start <= (state == WR_ADDR) && out_done && out_success;
    end
  end

  // Only one transaction is active so a plain OR and select suffice
  assign tx_send    = out_send | in_send;
  assign tx_request = in_send ? in_request : out_request;
  assign sending    = out_sending | in_sending;

  // Receiver only updates the payload on DATA0
  assign read_data = rx_event.payload;

  packet_sender packet_sender_i (
    .clock   (clock),
    .reset_n (reset_n),
    .send    (tx_send),
    .request (tx_request),
    .DP_out  (DP_out),
    .DM_out  (DM_out),
    .sent    (tx_sent),
    .busy    (tx_busy)
  );

  packet_receiver packet_receiver_i (
    .clock        (clock),
    .reset_n      (reset_n),
    .host_sending (sending),
    .DP_in        (DP_in),
    .DM_in        (DM_in),
    .rx_start     (rx_start),
    .rx_valid     (rx_valid),
    .rx_event     (rx_event)
  );

  out_transaction out_transaction_i (
    .clock    (clock),
    .reset_n  (reset_n),
    .start    (out_start),
    .endp     (txn_endp),
    .data     (txn_data),
    .sent     (tx_sent),
    .rx_start (rx_start),
    .rx_valid (rx_valid),
    .rx_event (rx_event),
    .send     (out_send),
    .request  (out_request),
    .sending  (out_sending),
    .done     (out_done),
    .success  (out_success),
    .failure  (out_failure)
  );

  in_transaction in_transaction_i (
    .clock    (clock),
    .reset_n  (reset_n),
    .start    (in_start),
    .endp     (txn_endp),
    .sent     (tx_sent),
    .rx_start (rx_start),
    .rx_valid (rx_valid),
    .rx_event (rx_event),
    .send     (in_send),
    .request  (in_request),
    .sending  (in_sending),
    .done     (in_done),
    .success  (in_success),
    .failure  (in_failure)
  );

  // The request merge needs a single sender at a time
  assert property (@(posedge clock) disable iff (!reset_n) !(out_send && in_send));

  // Sender has gone idle by the time an operation ends
  assert property (@(posedge clock) disable iff (!reset_n) finished |-> !tx_busy);

endmodule

`default_nettype wire

/* tests/usb_device_model.sv */
`timescale 1ns/1ps
`default_nettype none

module usb_device_model import usb_host_pkg::*; (
  input  logic       clock,
  input  logic       host_dp,
  input  logic       host_dm,
  input  logic       host_sending,
  input  logic       arm,
  input  logic [2:0] nak_count,
  input  logic       silent,
  output logic       dev_dp,
  output logic       dev_dm
);

  // Sparse page memory, one 64-bit word per page
  logic [63:0] mem [logic [15:0]];
  logic [15:0] addr_q;
  logic [3:0]  token_endp;
  logic [2:0]  nak_limit;
  logic [2:0]  naks_done;
  logic        silent_q;
  logic        prev_dp;

  // Unwritten pages read back a pattern of the page number
  function automatic logic [63:0] read_page(input logic [15:0] page);
    if (mem.exists(page))
      return mem[page];
    return {4{page}};
  endfunction

  // One cycle; config is picked up at the rising edge
  task automatic tick();
    @(posedge clock);
    if (arm) begin
      nak_limit = nak_count;
      silent_q  = silent;
      naks_done = 3'd0;
    end
    @(negedge clock);
  endtask

  // NRZI decode of the host line, unchanged level is a one
  task automatic next_bit(output logic b);
    tick();
    b       = (host_dp == prev_dp);
    prev_dp = host_dp;
  endtask

  task automatic receive_packet(output logic [3:0] pid, output logic [3:0] endp,
                                output logic [63:0] data, output logic ok);
    logic [7:0] window;
    logic [7:0] pid_byte;
    logic       b;
    int         i;
    window   = 8'd0;
    pid_byte = 8'd0;
    endp     = 4'd0;
    data     = 64'd0;
    // Hunt for sync, SE0 clears the history
    while (window != SYNC_PATTERN) begin
      next_bit(b);
      window = (!host_dp && !host_dm) ? 8'd0 : {b, window[7:1]};
    end
    for (i = 0; i < 8; i++) begin
      next_bit(b);
      pid_byte = {b, pid_byte[7:1]};
    end
    pid = pid_byte[3:0];
    ok  = (pid_byte[7:4] == ~pid_byte[3:0]);
    if (pid == PID_OUT || pid == PID_IN) begin
      for (i = 0; i < 4; i++) begin
        next_bit(b);
        endp = {b, endp[3:1]};
      end
    end else if (pid == PID_DATA0) begin
      for (i = 0; i < 64; i++) begin
        next_bit(b);
        data = {b, data[63:1]};
      end
    end
    // EOP, wait for SE0 and then the closing J
    while (host_dp || host_dm)
      tick();
    while (!host_dp && !host_dm)
      tick();
    prev_dp = host_dp;
  endtask

  // Sync, PID, complement, optional payload, then SE0 SE0 J
  task automatic send_packet(input logic [3:0] pid, input logic [63:0] data);
    logic [79:0] bits;
    logic        level;
    int          len;
    int          i;
    bits  = {data, ~pid, pid, SYNC_PATTERN};
    len   = (pid == PID_DATA0) ? 80 : 16;
    level = 1'b1;
    for (i = 0; i < len; i++) begin
      // Zero toggles the line
      if (!bits[i])
        level = ~level;
      dev_dp = level;
      dev_dm = ~level;
      tick();
    end
    dev_dp = 1'b0;
    dev_dm = 1'b0;
    tick();
    tick();
    dev_dp = 1'b1;
    dev_dm = 1'b0;
    tick();
  endtask

  // Turnaround: host must have let go of the bus first
  task automatic reply(input logic [3:0] pid, input logic [63:0] data);
    while (host_sending)
      tick();
    tick();
    send_packet(pid, data);
  endtask

  initial begin
    logic [3:0]  pid;
    logic [3:0]  endp;
    logic [63:0] data;
    logic        ok;
    dev_dp     = 1'b1;
    dev_dm     = 1'b0;
    prev_dp    = 1'b1;
    addr_q     = 16'd0;
    token_endp = 4'd0;
    nak_limit  = 3'd0;
    naks_done  = 3'd0;
    silent_q   = 1'b0;
    forever begin
      receive_packet(pid, endp, data, ok);
      if (ok && !silent_q) begin
        case (pid)
          PID_OUT: token_endp = endp;
          PID_DATA0: begin
            if (naks_done < nak_limit) begin
              naks_done = naks_done + 3'd1;
              reply(PID_NAK, 64'd0);
            end else begin
              // Address endpoint takes the page from the top 16 bits
              if (token_endp == ADDR_ENDP)
                addr_q = data[63:48];
              else if (token_endp == DATA_ENDP)
                mem[addr_q] = data;
              reply(PID_ACK, 64'd0);
            end
          end
          PID_IN: begin
            if (naks_done < nak_limit) begin
              naks_done = naks_done + 3'd1;
              reply(PID_NAK, 64'd0);
            end else begin
              reply(PID_DATA0, read_page(addr_q));
            end
          end
          // Host ACK after our DATA0 needs no answer
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* tests/usb_rw_host_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module usb_rw_host_tb import usb_host_pkg::*; ();

  typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_BOTH} op_t;

  // One table row of stimulus, device behavior and expected outcome
  typedef struct packed {
    op_t         op;
    logic [15:0] page;
    logic [63:0] data;
    logic [2:0]  naks;
    logic        silent;
    logic        expect_ok;
  } row_t;

  localparam int NUM_ROWS     = 15;
  localparam int RESET_CYCLES = 4;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES +
    NUM_ROWS * 2 * (MAX_RETRIES + 1) * (83 + 19 + RESPONSE_TIMEOUT + 10);

  logic        clock;
  logic        reset_n;
  logic        DP_in;
  logic        DM_in;
  logic        read_start;
  logic        write_start;
  logic [15:0] read_mempage;
  logic [15:0] write_mempage;
  logic [63:0] write_data;
  logic        DP_out;
  logic        DM_out;
  logic        sending;
  logic        finished;
  logic        read_success;
  logic        write_success;
  logic [63:0] read_data;

  logic        arm;
  logic [2:0]  nak_count;
  logic        silent;

  row_t        rows [NUM_ROWS];
  logic [63:0] ref_mem [logic [15:0]];
  int          failures;

  usb_rw_host usb_rw_host_i (
    .clock         (clock),
    .reset_n       (reset_n),
    .DP_in         (DP_in),
    .DM_in         (DM_in),
    .read_start    (read_start),
    .write_start   (write_start),
    .read_mempage  (read_mempage),
    .write_mempage (write_mempage),
    .write_data    (write_data),
    .DP_out        (DP_out),
    .DM_out        (DM_out),
    .sending       (sending),
    .finished      (finished),
    .read_success  (read_success),
    .write_success (write_success),
    .read_data     (read_data)
  );

  usb_device_model device_i (
    .clock        (clock),
    .host_dp      (DP_out),
    .host_dm      (DM_out),
    .host_sending (sending),
    .arm          (arm),
    .nak_count    (nak_count),
    .silent       (silent),
    .dev_dp       (DP_in),
    .dev_dm       (DM_in)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      failures++;
      $display("ERROR at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
      $display("tests failed");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  task automatic check_word(input string name, input logic [63:0] actual,
                            input logic [63:0] expected);
    if (actual !== expected) begin
      failures++;
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("tests failed");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  // Idle host drives J with every strobe low
  task automatic verify_idle();
    check_bit("sending", sending, 1'b0);
    check_bit("finished", finished, 1'b0);
    check_bit("read_success", read_success, 1'b0);
    check_bit("write_success", write_success, 1'b0);
    check_bit("DP_out", DP_out, 1'b1);
    check_bit("DM_out", DM_out, 1'b0);
  endtask

  task automatic set_row(input int idx, input op_t op, input logic [15:0] page,
                         input logic [63:0] data, input logic [2:0] naks,
                         input logic quiet, input logic ok);
    rows[idx] = '{op: op, page: page, data: data, naks: naks, silent: quiet, expect_ok: ok};
  endtask

  task automatic build_table();
    logic [63:0] w [7];
    int          i;
    for (i = 0; i < 7; i++)
      w[i] = {$urandom(), $urandom()};
    set_row(0, OP_WRITE, 16'h1234, w[0], 3'd0, 1'b0, 1'b1);
    set_row(1, OP_READ, 16'h1234, w[0], 3'd0, 1'b0, 1'b1);
    // Pages share the low bits so only the top nibble tells them apart
    set_row(2, OP_WRITE, 16'hA001, w[1], 3'd0, 1'b0, 1'b1);
    set_row(3, OP_WRITE, 16'h5001, w[2], 3'd0, 1'b0, 1'b1);
    set_row(4, OP_READ, 16'hA001, w[1], 3'd0, 1'b0, 1'b1);
    set_row(5, OP_READ, 16'h5001, w[2], 3'd0, 1'b0, 1'b1);
    // NAKs up to the retry limit are survived
    set_row(6, OP_WRITE, 16'h0777, w[3], 3'(MAX_RETRIES), 1'b0, 1'b1);
    set_row(7, OP_READ, 16'h0777, w[3], 3'(MAX_RETRIES), 1'b0, 1'b1);
    // One NAK too many
    set_row(8, OP_WRITE, 16'h1234, w[4], 3'(MAX_RETRIES + 1), 1'b0, 1'b0);
    set_row(9, OP_READ, 16'hA001, w[1], 3'(MAX_RETRIES + 1), 1'b0, 1'b0);
    // Silent device runs into the timeout
    set_row(10, OP_WRITE, 16'h5001, w[5], 3'd0, 1'b1, 1'b0);
    set_row(11, OP_READ, 16'hA001, w[1], 3'd0, 1'b1, 1'b0);
    set_row(12, OP_READ, 16'h1234, w[0], 3'd0, 1'b0, 1'b1);
    // Both strobes where the read wins
    set_row(13, OP_BOTH, 16'h5001, w[6], 3'd0, 1'b0, 1'b1);
    set_row(14, OP_READ, 16'h5001, w[2], 3'd0, 1'b0, 1'b1);
  endtask

  task automatic run_row(input row_t r);
    @(negedge clock);
    read_start    = (r.op != OP_WRITE);
    write_start   = (r.op != OP_READ);
    read_mempage  = r.page;
    write_mempage = r.page;
    write_data    = r.data;
    nak_count     = r.naks;
    silent        = r.silent;
    arm           = 1'b1;
    @(negedge clock);
    read_start  = 1'b0;
    write_start = 1'b0;
    arm         = 1'b0;
    // Watchdog bounds this wait
    while (!finished)
      @(negedge clock);
    if (r.op == OP_WRITE) begin
      check_bit("write_success", write_success, r.expect_ok);
      check_bit("read_success", read_success, 1'b0);
      if (r.expect_ok)
        ref_mem[r.page] = r.data;
    end else begin
      check_bit("read_success", read_success, r.expect_ok);
      check_bit("write_success", write_success, 1'b0);
      if (r.expect_ok)
        check_word("read_data", read_data, ref_mem[r.page]);
    end
    // Bus released once the operation is over
    @(negedge clock);
    verify_idle();
  endtask

  initial begin
    int i;
    reset_n       = 1'b0;
    read_start    = 1'b0;
    write_start   = 1'b0;
    read_mempage  = 16'd0;
    write_mempage = 16'd0;
    write_data    = 64'd0;
    arm           = 1'b0;
    nak_count     = 3'd0;
    silent        = 1'b0;
    failures      = 0;
    void'($urandom(78));
    build_table();
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    reset_n = 1'b1;
    verify_idle();
    for (i = 0; i < NUM_ROWS; i++)
      run_row(rows[i]);
    if (failures == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("tests failed");
      $fatal(1, "Checks failed");
    end
  end

  // Budget covers every row at its worst retry and timeout path
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("Watchdog expired before all operations finished");
    $display("tests failed");
    $fatal(1, "Timeout");
  end

endmodule

`default_nettype wire

/* src.f */
src/usb_host_pkg.sv
src/packet_sender.sv
src/packet_receiver.sv
src/out_transaction.sv
src/in_transaction.sv
src/usb_rw_host.sv
tests/usb_device_model.sv
tests/usb_rw_host_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator; pass is decided from the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module usb_rw_host_tb -o sim
./obj_dir/sim | tee sim.log
grep -q "all tests passed" sim.log
